// ==== filelist.f ====
+incdir+common
common/galaksija_pkg.sv
hw/frame_int_timer.sv
memory/addr_decode.sv
hw/bus_cycle_ctrl.sv
memory/mem_banks.sv
keyboard/key_matrix.sv
hw/galaksija_bus_top.sv
sim/galaksija_asserts.sv
sim/tb_galaksija.sv

// ==== sim/tb_galaksija.sv ====
module tb_galaksija import galaksija_pkg::*; ();

	localparam int timeout_cycles = 3000; // about twice the full test run

	logic        sysclk = 1'b0;
	logic        cpu_resetn;
	bus_addr_u   addr;
	logic [7:0]  wdata;
	logic        mreq_n;
	logic        rd_n;
	logic        wr_n;
	logic [7:0]  rdata;
	logic        int_n;
	logic [12:0] rom_addr;
	logic [7:0]  rom_data;
	ps2_event_t  ps2_key;
	logic [7:0]  io_latch;

	logic [7:0]  ref_mem [65536]; // reference for vram and main ram
	logic [63:0] keys_held;       // expected key matrix
	logic [7:0]  exp_latch;
	int          cycle_count = 0;

	galaksija_bus_top #(
		.int_period(40)
	) u_dut (
		.sysclk    (sysclk),
		.cpu_resetn(cpu_resetn),
		.addr      (addr),
		.wdata     (wdata),
		.mreq_n    (mreq_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.rdata     (rdata),
		.int_n     (int_n),
		.rom_addr  (rom_addr),
		.rom_data  (rom_data),
		.ps2_key   (ps2_key),
		.io_latch  (io_latch)
	);

	always #4 sysclk = ~sysclk;

	// rom contents, every address bit shows up in the byte
	function automatic logic [7:0] rom_byte(input logic [12:0] a);
		return a[7:0] ^ {a[12:8], 3'b101};
	endfunction

	assign rom_data = rom_byte(rom_addr); // rom model answers comb

	always @(posedge sysclk) begin
		cycle_count++;
		if (u_dut.u_asserts.fail_count != 0) begin
			$display("ERROR: an assertion inside the DUT failed");
			$display("Verification failed");
			$fatal(1, "assertion");
		end else if (cycle_count >= timeout_cycles) begin
			$display("ERROR: the run did not finish within %0d cycles", timeout_cycles);
			$display("Verification failed");
			$fatal(1, "timeout");
		end
	end

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, msg, actual,
				expected);
			$display("Verification failed");
			$fatal(1, "mismatch");
		end
	endtask

	// ps/2 set 2 codes used by the tests, 0 = not in the matrix
	function automatic int scan_to_key(input logic [7:0] code);
		case (code)
			8'h1c:        return 1;  // a
			8'h73:        return 37; // keypad 5
			8'h12, 8'h59: return 53; // shifts
			default:      return 0;
		endcase
	endfunction

	// what the cpu should read back from the memory map
	function automatic logic [7:0] expect_read(input logic [15:0] a);
		if (a < 16'h2000) return rom_byte(a[12:0]);
		else if (a < 16'h2800) return (a[5:0] != 0 && keys_held[a[5:0]]) ? 8'hfe : 8'hff;
		else if (a < 16'hc000) return ref_mem[a];
		else return 8'hff;
	endfunction

	task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge sysclk);
		addr.raw <= a;
		wdata    <= d;
		mreq_n   <= 1'b0;
		wr_n     <= 1'b0;
		repeat (3) @(posedge sysclk); // strobes held 3 cycles
		mreq_n   <= 1'b1;
		wr_n     <= 1'b1;
		if (a >= 16'h2000 && a < 16'h2800) exp_latch = d;
		else if (a >= 16'h2800 && a < 16'hc000) ref_mem[a] = d;
	endtask

	task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
		@(posedge sysclk);
		addr.raw <= a;
		mreq_n   <= 1'b0;
		rd_n     <= 1'b0;
		repeat (3) @(posedge sysclk);
		d = rdata; // registered on the edge before
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
	endtask

	task automatic read_and_compare(input logic [15:0] a, input string msg);
		logic [7:0] d;
		bus_read(a, d);
		check(d, expect_read(a), $sformatf("%s at %04h", msg, a));
	endtask

	task automatic ps2_event(input logic [7:0] code, input logic pressed);
		int idx;
		idx = scan_to_key(code);
		@(posedge sysclk);
		ps2_key <= '{toggle: !ps2_key.toggle, pressed: pressed, extended: 1'b0, code: code};
		repeat (2) @(posedge sysclk); // matrix updates on the first edge
		if (idx != 0) keys_held[idx] = pressed;
	endtask

	task automatic test_reset();
		check(io_latch, 8'h00, "io_latch after reset");
		check(int_n, 1'b1, "int_n after reset");
		check(rdata, 8'hff, "rdata after reset");
		read_and_compare(16'h2001, "key read after reset");
	endtask

	task automatic test_ram();
		logic [15:0] bases [5];
		logic [15:0] masks [5];
		logic [15:0] addrs [40];
		bases = '{16'h2800, 16'h3000, 16'h4000, 16'h8000, 16'hc000};
		masks = '{16'h07ff, 16'h0fff, 16'h3fff, 16'h3fff, 16'h3fff};
		for (int i = 0; i < 40; i++) begin
			addrs[i] = bases[i / 8] | (16'($urandom) & masks[i / 8]);
			bus_write(addrs[i], 8'($urandom));
		end
		foreach (addrs[i]) read_and_compare(addrs[i], "ram round trip");
	endtask

	task automatic test_rom();
		for (int i = 0; i < 6; i++) read_and_compare(16'($urandom) & 16'h1fff, "rom read");
		bus_write(16'h0123, 8'hc3); // ignored by rom space
		check(io_latch, exp_latch, "io_latch after rom write");
		read_and_compare(16'h0123, "rom after write");
	endtask

	task automatic test_keyboard();
		ps2_event(8'h1c, 1'b1);
		ps2_event(8'h73, 1'b1);
		ps2_event(8'h12, 1'b1);
		for (int k = 0; k < 64; k++) read_and_compare(16'h2000 + k, "held keys");
		ps2_event(8'h1c, 1'b0);
		read_and_compare(16'h2001, "a released");
		ps2_event(8'h73, 1'b0);
		read_and_compare(16'h2025, "keypad 5 released");
		ps2_event(8'h12, 1'b0);
		read_and_compare(16'h2035, "shift released");
		ps2_event(8'h0e, 1'b1); // backtick, not in the matrix
		for (int k = 0; k < 64; k++) read_and_compare(16'h2000 + k, "unmapped code");
	endtask

	task automatic test_latch();
		bus_write(16'h2345, 8'ha7);
		check(io_latch, exp_latch, "io_latch load");
		read_and_compare(16'h2345, "key byte at latch address");
	endtask

	task automatic test_interrupt();
		int last_low;
		int lows;
		last_low = -1;
		lows = 0;
		for (int c = 0; c < 200; c++) begin
			@(posedge sysclk);
			if (!int_n) begin
				if (last_low >= 0) check(c - last_low, 40, "int_n period");
				last_low = c;
				lows++;
			end
		end
		check(lows, 5, "int_n pulses in 200 cycles");
	endtask

	initial begin
		cpu_resetn = 1'b0;
		addr       = '0;
		wdata      = 8'h00;
		mreq_n     = 1'b1;
		rd_n       = 1'b1;
		wr_n       = 1'b1;
		ps2_key    = '0;
		keys_held  = '0;
		exp_latch  = 8'h00;
		void'($urandom(32'h43cc));
		repeat (4) @(posedge sysclk);
		cpu_resetn <= 1'b1;
		@(posedge sysclk);
		test_reset();
		test_ram();
		test_rom();
		test_keyboard();
		test_latch();
		test_interrupt();
		if (u_dut.u_asserts.fail_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== sim/galaksija_asserts.sv ====
module galaksija_asserts import galaksija_pkg::*; (
	input logic     sysclk,
	input logic     cpu_resetn,
	input logic     rd_en,
	input logic     wr_en,
	input logic     int_n,
	input bus_req_t req
);

	int fail_count = 0; // assertion failures so far

	// one enable per bus cycle
	a_wr_single: assert property (@(posedge sysclk) disable iff (!cpu_resetn)
		wr_en |=> !wr_en) else begin
		fail_count++;
		$error("wr_en high for two cycles");
	end

	a_rd_single: assert property (@(posedge sysclk) disable iff (!cpu_resetn)
		rd_en |=> !rd_en) else begin
		fail_count++;
		$error("rd_en high for two cycles");
	end

	a_int_pulse: assert property (@(posedge sysclk) disable iff (!cpu_resetn)
		!int_n |=> int_n) else begin
		fail_count++;
		$error("int_n low for two cycles");
	end

	// rom space never sees a write enable
	a_no_rom_write: assert property (@(posedge sysclk) disable iff (!cpu_resetn)
		wr_en |-> req.region != REG_ROM) else begin
		fail_count++;
		$error("wr_en issued for a rom address");
	end

endmodule

bind galaksija_bus_top galaksija_asserts u_asserts (.*);

// ==== hw/galaksija_bus_top.sv ====
`include "galaksija_defs.svh"

module galaksija_bus_top import galaksija_pkg::*; #(
	parameter int unsigned int_period = `GAL_INT_PERIOD
) (
	input  logic                   sysclk,
	input  logic                   cpu_resetn,
	input  bus_addr_u              addr,
	input  logic [7:0]             wdata,
	input  logic                   mreq_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	output logic [7:0]             rdata,
	output logic                   int_n,
	output logic [`GAL_ROM_AW-1:0] rom_addr,
	input  logic [7:0]             rom_data,
	input  ps2_event_t             ps2_key,
	output logic [7:0]             io_latch
);

	mem_region_e          region;    // decoded from the live address
	bus_req_t             req;       // latched bus cycle
	logic                 rd_en;
	logic                 wr_en;
	logic [`GAL_KEYS-1:0] key_state; // held keys

	frame_int_timer #(
		.int_period(int_period)
	) u_frame_int_timer (
		.sysclk    (sysclk),
		.cpu_resetn(cpu_resetn),
		.int_n     (int_n)
	);

	addr_decode u_addr_decode (
		.addr  (addr),
		.region(region)
	);

	bus_cycle_ctrl u_bus_cycle_ctrl (
		.sysclk    (sysclk),
		.cpu_resetn(cpu_resetn),
		.addr      (addr),
		.wdata     (wdata),
		.mreq_n    (mreq_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.region    (region),
		.req       (req),
		.rd_en     (rd_en),
		.wr_en     (wr_en)
	);

	mem_banks u_mem_banks (
		.sysclk    (sysclk),
		.cpu_resetn(cpu_resetn),
		.req       (req),
		.rd_en     (rd_en),
		.wr_en     (wr_en),
		.key_state (key_state),
		.rom_data  (rom_data),
		.rom_addr  (rom_addr),
		.rdata     (rdata),
		.io_latch  (io_latch)
	);

	key_matrix u_key_matrix (
		.sysclk    (sysclk),
		.cpu_resetn(cpu_resetn),
		.ps2_key   (ps2_key),
		.key_state (key_state)
	);

endmodule

// ==== keyboard/key_matrix.sv ====
`include "galaksija_defs.svh"

module key_matrix import galaksija_pkg::*; (
	input  logic                 sysclk,
	input  logic                 cpu_resetn,
	input  ps2_event_t           ps2_key,
	output logic [`GAL_KEYS-1:0] key_state
);

	localparam int key_iw = $clog2(`GAL_KEYS);

	logic              toggle_q; // last seen toggle
	logic [key_iw-1:0] ev_idx;   // 0 means no key

	// scan code to galaksija key index
	function automatic logic [key_iw-1:0] key_index(input logic [7:0] code);
		logic [key_iw-1:0] idx;
		case (code)
			8'h1c: idx = 6'd1;  // a
			8'h32: idx = 6'd2;
			8'h21: idx = 6'd3;
			8'h23: idx = 6'd4;
			8'h24: idx = 6'd5;
			8'h2b: idx = 6'd6;
			8'h34: idx = 6'd7;
			8'h33: idx = 6'd8;
			8'h43: idx = 6'd9;
			8'h3b: idx = 6'd10;
			8'h42: idx = 6'd11;
			8'h4b: idx = 6'd12;
			8'h3a: idx = 6'd13;
			8'h31: idx = 6'd14;
			8'h44: idx = 6'd15;
			8'h4d: idx = 6'd16;
			8'h15: idx = 6'd17;
			8'h2d: idx = 6'd18;
			8'h1b: idx = 6'd19;
			8'h2c: idx = 6'd20;
			8'h3c: idx = 6'd21;
			8'h2a: idx = 6'd22;
			8'h1d: idx = 6'd23;
			8'h22: idx = 6'd24;
			8'h35: idx = 6'd25;
			8'h1a: idx = 6'd26; // z
			8'h66: idx = 6'd29; // backspace
			8'h29: idx = 6'd31; // space
			8'h45, 8'h70: idx = 6'd32; // 0, main row and keypad
			8'h16, 8'h69: idx = 6'd33;
			8'h1e, 8'h72: idx = 6'd34;
			8'h26, 8'h7a: idx = 6'd35;
			8'h25, 8'h6b: idx = 6'd36;
			8'h2e, 8'h73: idx = 6'd37;
			8'h36, 8'h74: idx = 6'd38;
			8'h3d, 8'h6c: idx = 6'd39;
			8'h3e, 8'h75: idx = 6'd40;
			8'h46, 8'h7d: idx = 6'd41; // 9
			8'h4c: idx = 6'd42; // ;
			8'h7c: idx = 6'd43; // keypad * stands in for :
			8'h41: idx = 6'd44; // ,
			8'h55: idx = 6'd45; // =
			8'h49: idx = 6'd46; // .
			8'h4a: idx = 6'd47; // /
			8'h5a: idx = 6'd48; // enter
			8'h76: idx = 6'd49; // esc
			8'h12, 8'h59: idx = 6'd53; // left and right shift
			default: idx = '0;
		endcase
		return idx;
	endfunction

	always_comb begin
		if (ps2_key.extended) begin
			// only keypad enter and keypad slash among e0 codes
			ev_idx = (ps2_key.code == 8'h5a || ps2_key.code == 8'h4a) ?
				key_index(ps2_key.code) : '0;
		end else begin
			ev_idx = key_index(ps2_key.code);
		end
	end

	always_ff @(posedge sysclk) begin
		if (!cpu_resetn) begin
			toggle_q  <= ps2_key.toggle; // no event out of reset
			key_state <= '0;
		end else begin
			toggle_q <= ps2_key.toggle;
			if (toggle_q != ps2_key.toggle && ev_idx != '0) begin
				key_state[ev_idx] <= ps2_key.pressed; // make sets, break clears
			end
		end
	end

endmodule

// ==== memory/mem_banks.sv ====
`include "galaksija_defs.svh"

module mem_banks import galaksija_pkg::*; (
	input  logic                   sysclk,
	input  logic                   cpu_resetn,
	input  bus_req_t               req,
	input  logic                   rd_en,
	input  logic                   wr_en,
	input  logic [`GAL_KEYS-1:0]   key_state,
	input  logic [7:0]             rom_data,
	output logic [`GAL_ROM_AW-1:0] rom_addr,
	output logic [7:0]             rdata,
	output logic [7:0]             io_latch
);

	localparam int key_iw = $clog2(`GAL_KEYS);

	logic [7:0] vram [2**`GAL_VRAM_AW]; // 2 KiB screen memory
	logic [7:0] ram0 [2**`GAL_RAM0_AW]; // 4 KiB
	logic [7:0] ram1 [2**`GAL_RAM_AW];  // 16 KiB
	logic [7:0] ram2 [2**`GAL_RAM_AW];  // 16 KiB

	logic [key_iw-1:0] key_idx;
	logic              key_held;

	assign rom_addr = req.addr.raw[`GAL_ROM_AW-1:0]; // external rom answers comb
	assign key_idx  = req.addr.ram_view.offset[key_iw-1:0];
	assign key_held = key_state[key_idx];

	always_ff @(posedge sysclk) begin
		if (wr_en) begin
			case (req.region)
				REG_VRAM: vram[req.addr.io_view.offset] <= req.wdata;
				REG_RAM0: ram0[req.addr.ram_view.offset[`GAL_RAM0_AW-1:0]] <= req.wdata;
				REG_RAM1: ram1[req.addr.ram_view.offset] <= req.wdata;
				REG_RAM2: ram2[req.addr.ram_view.offset] <= req.wdata;
				default: ; // rom, latch and empty space
			endcase
		end
	end

	always_ff @(posedge sysclk) begin
		if (!cpu_resetn) begin
			io_latch <= 8'h00;
			rdata    <= 8'hff; // idle bus
		end else begin
			if (wr_en && req.region == REG_KEY) begin
				io_latch <= req.wdata; // write-only latch
			end
			if (rd_en) begin
				case (req.region)
					REG_ROM:  rdata <= rom_data;
					REG_KEY:  rdata <= key_held ? 8'hfe : 8'hff; // held key pulls bit 0 low
					REG_VRAM: rdata <= vram[req.addr.io_view.offset];
					REG_RAM0: rdata <= ram0[req.addr.ram_view.offset[`GAL_RAM0_AW-1:0]];
					REG_RAM1: rdata <= ram1[req.addr.ram_view.offset];
					REG_RAM2: rdata <= ram2[req.addr.ram_view.offset];
					default:  rdata <= 8'hff;
				endcase
			end
		end
	end

endmodule

// ==== hw/bus_cycle_ctrl.sv ====
module bus_cycle_ctrl import galaksija_pkg::*; (
	input  logic        sysclk,
	input  logic        cpu_resetn,
	input  bus_addr_u   addr,
	input  logic [7:0]  wdata,
	input  logic        mreq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  mem_region_e region,
	output bus_req_t    req,
	output logic        rd_en,
	output logic        wr_en
);

	typedef enum logic [1:0] {
		IDLE,     // waiting for strobes
		ACCESS,   // enable high this cycle
		DATA,     // read data on rdata
		WAIT_END  // until mreq_n rises
	} state_e;

	state_e state;
	logic   start;

	// memory cycle with exactly one of rd/wr active
	assign start = !mreq_n && (rd_n ^ wr_n);

	always_ff @(posedge sysclk) begin
		if (state == IDLE && start) begin
			req <= '{addr: addr, wdata: wdata, region: region}; // snapshot of the cycle
		end
	end

	always_ff @(posedge sysclk) begin
		if (!cpu_resetn) begin
			state <= IDLE;
			rd_en <= 1'b0;
			wr_en <= 1'b0;
		end else begin
			rd_en <= 1'b0; // enables last one cycle
			wr_en <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						rd_en <= !rd_n;
						wr_en <= !wr_n && region != REG_ROM; // rom is read only
						state <= ACCESS;
					end
				end
				ACCESS:   state <= DATA;
				DATA:     state <= WAIT_END;
				WAIT_END: if (mreq_n) state <= IDLE; // strobes released
				default:  state <= IDLE;
			endcase
		end
	end

endmodule

// ==== memory/addr_decode.sv ====
`include "galaksija_defs.svh"

module addr_decode import galaksija_pkg::*; (
	input  bus_addr_u   addr,
	output mem_region_e region
);

	always_comb begin
		region = REG_NONE;
		if (addr.ram_view.bank == 2'd0) begin
			// low 16 KiB split in 2 KiB pages
			if (addr.io_view.page < `GAL_PAGE_KEY) begin
				region = REG_ROM; // pages 0-3
			end else if (addr.io_view.page == `GAL_PAGE_KEY) begin
				region = REG_KEY;
			end else if (addr.io_view.page == `GAL_PAGE_VRAM) begin
				region = REG_VRAM;
			end else if (addr.io_view.page >= `GAL_PAGE_RAM0) begin
				region = REG_RAM0; // pages 6-7
			end
		end else begin
			case (addr.ram_view.bank)
				2'd1:    region = REG_RAM1;
				2'd2:    region = REG_RAM2;
				default: region = REG_NONE; // top bank not fitted
			endcase
		end
	end

endmodule

// ==== hw/frame_int_timer.sv ====
`include "galaksija_defs.svh"

module frame_int_timer #(
	parameter int unsigned int_period = `GAL_INT_PERIOD
) (
	input  logic sysclk,
	input  logic cpu_resetn,
	output logic int_n
);

	localparam int unsigned cnt_w = (int_period > 1) ? $clog2(int_period) : 1;
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(int_period - 1);

	logic [cnt_w-1:0] cnt; // cycles since last pulse

	always_ff @(posedge sysclk) begin
		if (!cpu_resetn) begin
			cnt   <= '0;
			int_n <= 1'b1;
		end else if (cnt == cnt_last) begin
			cnt   <= '0;   // wrap
			int_n <= 1'b0; // one cycle low
		end else begin
			cnt   <= cnt + 1'b1;
			int_n <= 1'b1;
		end
	end

endmodule

// ==== common/galaksija_pkg.sv ====
package galaksija_pkg;

	typedef struct packed {
		logic [4:0]  page;   // 2 KiB page, rom/key/vram/ram0 below 0x4000
		logic [10:0] offset; // byte inside the page
	} io_view_t;

	typedef struct packed {
		logic [1:0]  bank;   // 16 KiB bank
		logic [13:0] offset; // byte inside the bank
	} ram_view_t;

	// one cpu address, decoded either by page or by bank
	typedef union packed {
		logic [15:0] raw;
		io_view_t    io_view;
		ram_view_t   ram_view;
	} bus_addr_u;

	typedef struct packed {
		logic       toggle;   // flips once per event
		logic       pressed;  // make = 1, break = 0
		logic       extended; // e0 prefix seen
		logic [7:0] code;     // set 2 scan code
	} ps2_event_t;

	typedef enum logic [2:0] {
		REG_ROM,  // 0x0000-0x1fff, external
		REG_KEY,  // 0x2000-0x27ff, keys read, latch write
		REG_VRAM, // 0x2800-0x2fff
		REG_RAM0, // 0x3000-0x3fff
		REG_RAM1, // 0x4000-0x7fff
		REG_RAM2, // 0x8000-0xbfff
		REG_NONE  // 0xc000-0xffff, unpopulated
	} mem_region_e;

	typedef struct packed {
		bus_addr_u   addr;
		logic [7:0]  wdata;
		mem_region_e region;
	} bus_req_t;

endpackage

// ==== common/galaksija_defs.svh ====
`ifndef GALAKSIJA_DEFS_SVH
`define GALAKSIJA_DEFS_SVH

// memory sizes
`define GAL_ROM_AW 13
`define GAL_VRAM_AW 11
`define GAL_RAM0_AW 12
`define GAL_RAM_AW 14

// keyboard matrix size
`define GAL_KEYS 64

// 2 KiB page numbers inside the low 16 KiB
`define GAL_PAGE_KEY 5'd4
`define GAL_PAGE_VRAM 5'd5
`define GAL_PAGE_RAM0 5'd6

// 25 MHz / 100 Hz
`define GAL_INT_PERIOD 250000

`endif
